//--- src/tft_consts.svh
//********************
// Clock rate, tick divider and SPI timing defaults
// Panel reset and wake delays, window size
// Fill colour and ILI9341 command codes
//********************
`ifndef TFT_CONSTS_SVH
`define TFT_CONSTS_SVH

// System clock
`define TFT_CLK_HZ 100000000

// Sequencer state tick at 100 Hz
`define TFT_TICK_DIV (`TFT_CLK_HZ / 100)

// SPI clock is CLK / (2 * half period)
`define TFT_SPI_HALF 2

// 10 ms panel reset, 120 ms wake after sleep-out
`define TFT_RST_CYCLES (`TFT_CLK_HZ / 100)
`define TFT_WAKE_CYCLES (`TFT_CLK_HZ / 1000 * 120)

// Panel geometry in portrait mode
`define TFT_COLS 240
`define TFT_ROWS 320

// RGB565 blue
`define TFT_FILL_COLOR 16'h001F

// ILI9341 commands
`define TFT_CMD_CASET 8'h2A
`define TFT_CMD_PASET 8'h2B
`define TFT_CMD_RAMWR 8'h2C
`define TFT_CMD_SLPOUT 8'h11
`define TFT_CMD_COLMOD 8'h3A
`define TFT_COLMOD_565 8'h55
`define TFT_CMD_DISPON 8'h29

`endif

//--- src/tft_pkg.sv
//********************
// Byte kind flag, controller power-up steps
// and fill sequencer state types
//********************
package tft_pkg;

    // Meaning of the data/command flag
    typedef enum logic {
        kind_data = 1'b0,
        kind_cmd  = 1'b1
    } byte_kind_t;

    // Power-up steps in the order the controller steps through them
    typedef enum logic [3:0] {
        step_rst_low,
        step_rst_wait,
        step_slpout,
        step_sleep_wait,
        step_colmod,
        step_colmod_data,
        step_dispon,
        step_run
    } init_step_t;

    typedef enum logic [2:0] {
        fill_idle,
        fill_wait_ready,
        fill_caset,
        fill_paset,
        fill_ramwr,
        fill_stream,
        fill_complete
    } fill_state_t;

endpackage

//--- src/lcd_byte_if.sv
//********************
// Byte link between fill sequencer and LCD controller
//********************
`timescale 1ns/1ns

interface lcd_byte_if;
    import tft_pkg::*;

    // Client side
    logic       load;
    logic [7:0] data;
    byte_kind_t kind;

    // Server side
    logic       busy;
    logic       ready;

    modport client (
        output load,
        output data,
        output kind,
        input  busy,
        input  ready
    );

    modport server (
        input  load,
        input  data,
        input  kind,
        output busy,
        output ready
    );

endinterface

//--- src/spi_byte_tx.sv
//********************
// SPI mode 0 byte transmitter, MSB first
// Chip select framing per byte
//********************
`timescale 1ns/1ns

module spi_byte_tx #(
    parameter int half_div = 2
) (
    input  logic       CLK_100MHz,
    input  logic       rst,
    input  logic       start,
    input  logic [7:0] byte_in,
    output logic       busy,
    output logic       sck,
    output logic       sdo,
    output logic       cs_n
);

    localparam int DW = (half_div > 1) ? $clog2(half_div) : 1;

    logic [7:0]    shreg;
    logic [2:0]    bit_cnt;
    logic [DW-1:0] div_cnt;
    logic          half_done;

    assign half_done = (div_cnt == DW'(half_div - 1));

    // Line is held low between frames
    assign sdo = cs_n ? 1'b0 : shreg[7];

    always_ff @(posedge CLK_100MHz) begin
        if (rst) begin
            busy    <= 1'b0;
            cs_n    <= 1'b1;
            sck     <= 1'b0;
            bit_cnt <= '0;
            div_cnt <= '0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                cs_n    <= 1'b0;
                bit_cnt <= '0;
                div_cnt <= '0;
            end
        end else if (half_done) begin
            div_cnt <= '0;
            sck     <= ~sck;
            // Falling edge closes a bit
            if (sck) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    busy <= 1'b0;
                    cs_n <= 1'b1;
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Next bit appears on the falling edge, panel samples on the rising one
    always_ff @(posedge CLK_100MHz) begin
        if (!busy && start) begin
            shreg <= byte_in;
        end else if (busy && half_done && sck) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

    // Caller must wait out the frame before the next byte
    a_no_start_busy: assert property (
        @(posedge CLK_100MHz) disable iff (rst)
        $rose(start) |-> !busy
    ) else $error("spi_byte_tx: start raised while busy");

endmodule

//--- src/lcd_ctrl.sv
//********************
// ILI9341 controller with panel reset, power-up commands
// and client byte forwarding with D/C control
//********************
`timescale 1ns/1ns
`include "tft_consts.svh"

module lcd_ctrl #(
    parameter int rst_cycles  = `TFT_RST_CYCLES,
    parameter int wake_cycles = `TFT_WAKE_CYCLES
) (
    input  logic         CLK_100MHz,
    input  logic         rst,
    lcd_byte_if.server   host,
    output logic         tft_reset,
    output logic         tft_dc,
    output logic         sck,
    output logic         sdo,
    output logic         cs_n
);
    import tft_pkg::*;

    localparam int DLY_MAX = (rst_cycles > wake_cycles) ? rst_cycles : wake_cycles;
    localparam int DW      = $clog2(DLY_MAX + 1);

    init_step_t    step_q;
    init_step_t    next_step;
    logic [DW-1:0] dly_cnt;
    logic [DW-1:0] dly_end;
    logic          issued;
    logic          tx_start;
    logic [7:0]    tx_byte;
    logic          tx_busy;
    logic [7:0]    init_byte;
    byte_kind_t    init_kind;

    assign next_step = init_step_t'(step_q + 4'd1);
    assign dly_end   = (step_q == step_sleep_wait) ? DW'(wake_cycles - 1) : DW'(rst_cycles - 1);

    // Busy covers the cycle between accept and serializer start
    assign host.busy  = tx_start || tx_busy;
    assign host.ready = (step_q == step_run);

    // Power-up byte for each send step
    always_comb begin
        case (step_q)
            step_slpout:      {init_kind, init_byte} = {kind_cmd, `TFT_CMD_SLPOUT};
            step_colmod:      {init_kind, init_byte} = {kind_cmd, `TFT_CMD_COLMOD};
            step_colmod_data: {init_kind, init_byte} = {kind_data, `TFT_COLMOD_565};
            step_dispon:      {init_kind, init_byte} = {kind_cmd, `TFT_CMD_DISPON};
            default:          {init_kind, init_byte} = {kind_data, 8'h00};
        endcase
    end

    always_ff @(posedge CLK_100MHz) begin
        if (rst) begin
            step_q    <= step_rst_low;
            dly_cnt   <= '0;
            issued    <= 1'b0;
            tx_start  <= 1'b0;
            tft_reset <= 1'b0;
            tft_dc    <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (step_q)
                step_rst_low, step_rst_wait, step_sleep_wait: begin
                    if (dly_cnt == dly_end) begin
                        dly_cnt <= '0;
                        step_q  <= next_step;
                        // Release the panel after the low phase
                        if (step_q == step_rst_low) begin
                            tft_reset <= 1'b1;
                        end
                    end else begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end
                end
                step_slpout, step_colmod, step_colmod_data, step_dispon: begin
                    if (!issued) begin
                        tx_start <= 1'b1;
                        tx_byte  <= init_byte;
                        tft_dc   <= (init_kind == kind_data);
                        issued   <= 1'b1;
                    end else if (!tx_start && !tx_busy) begin
                        issued <= 1'b0;
                        step_q <= next_step;
                    end
                end
                default: begin
                    // Pass-through once ready
                    if (host.load && !host.busy) begin
                        tx_start <= 1'b1;
                        tx_byte  <= host.data;
                        tft_dc   <= (host.kind == kind_data);
                    end
                end
            endcase
        end
    end

    spi_byte_tx #(
        .half_div (`TFT_SPI_HALF)
    ) spi_byte_tx_inst (
        .CLK_100MHz (CLK_100MHz),
        .rst        (rst),
        .start      (tx_start),
        .byte_in    (tx_byte),
        .busy       (tx_busy),
        .sck        (sck),
        .sdo        (sdo),
        .cs_n       (cs_n)
    );

    // Client must not request bytes during power-up
    a_load_after_ready: assert property (
        @(posedge CLK_100MHz) disable iff (rst)
        $rose(host.load) |-> host.ready
    ) else $error("lcd_ctrl: load raised before ready");

endmodule

//--- src/lcd_fill_seq.sv
//********************
// Fill sequencer for address window setup,
// memory write and one colour for every pixel
//********************
`timescale 1ns/1ns
`include "tft_consts.svh"

module lcd_fill_seq #(
    parameter int cols     = `TFT_COLS,
    parameter int rows     = `TFT_ROWS,
    parameter int tick_div = `TFT_TICK_DIV
) (
    input  logic        CLK_100MHz,
    input  logic        rst,
    input  logic        restart,
    lcd_byte_if.client  lcd,
    output logic        streaming
);
    import tft_pkg::*;

    localparam int          TW        = (tick_div > 1) ? $clog2(tick_div) : 1;
    localparam int          PIX_BYTES = 2 * cols * rows;
    localparam int          PW        = $clog2(PIX_BYTES + 1);
    localparam logic [15:0] COL_END   = 16'(cols - 1);
    localparam logic [15:0] ROW_END   = 16'(rows - 1);
    localparam logic [15:0] FILL      = `TFT_FILL_COLOR;

    fill_state_t   state_q;
    logic [TW-1:0] tick_cnt;
    logic          tick;
    logic [2:0]    byte_idx;
    logic [PW-1:0] pix_cnt;
    logic [15:0]   win_end;
    logic [7:0]    win_byte;
    byte_kind_t    win_kind;
    logic          bus_free;

    assign bus_free  = !lcd.busy && !lcd.load;
    assign streaming = (state_q == fill_stream) || (state_q == fill_complete);

    // Slow state tick
    always_ff @(posedge CLK_100MHz) begin
        if (rst) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else if (tick_cnt == TW'(tick_div - 1)) begin
            tick_cnt <= '0;
            tick     <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            tick     <= 1'b0;
        end
    end

    // CASET and PASET share one layout of cmd, start hi/lo and end hi/lo
    assign win_end = (state_q == fill_caset) ? COL_END : ROW_END;

    always_comb begin
        case (byte_idx)
            3'd0:    {win_kind, win_byte} = (state_q == fill_caset) ?
                         {kind_cmd, `TFT_CMD_CASET} : {kind_cmd, `TFT_CMD_PASET};
            3'd3:    {win_kind, win_byte} = {kind_data, win_end[15:8]};
            3'd4:    {win_kind, win_byte} = {kind_data, win_end[7:0]};
            default: {win_kind, win_byte} = {kind_data, 8'h00};
        endcase
    end

    always_ff @(posedge CLK_100MHz) begin
        if (rst) begin
            state_q  <= fill_idle;
            byte_idx <= '0;
            pix_cnt  <= '0;
            lcd.load <= 1'b0;
        end else begin
            // Drop load once the controller has taken the byte
            if (lcd.busy) begin
                lcd.load <= 1'b0;
            end
            if (tick) begin
                if (restart) begin
                    state_q <= fill_idle;
                end else begin
                    case (state_q)
                        fill_idle: begin
                            byte_idx <= '0;
                            pix_cnt  <= '0;
                            state_q  <= fill_wait_ready;
                        end
                        fill_wait_ready: begin
                            if (lcd.ready && !lcd.busy) begin
                                byte_idx <= '0;
                                state_q  <= fill_caset;
                            end
                        end
                        fill_caset, fill_paset: begin
                            if (bus_free) begin
                                if (byte_idx == 3'd5) begin
                                    byte_idx <= '0;
                                    state_q  <= (state_q == fill_caset) ? fill_paset : fill_ramwr;
                                end else begin
                                    lcd.load <= 1'b1;
                                    lcd.data <= win_byte;
                                    lcd.kind <= win_kind;
                                    byte_idx <= byte_idx + 3'd1;
                                end
                            end
                        end
                        fill_ramwr: begin
                            if (bus_free) begin
                                lcd.load <= 1'b1;
                                lcd.data <= `TFT_CMD_RAMWR;
                                lcd.kind <= kind_cmd;
                                pix_cnt  <= '0;
                                state_q  <= fill_stream;
                            end
                        end
                        fill_stream: begin
                            if (bus_free) begin
                                if (pix_cnt == PW'(PIX_BYTES)) begin
                                    state_q <= fill_complete;
                                end else begin
                                    // High byte on even counts
                                    lcd.load <= 1'b1;
                                    lcd.data <= pix_cnt[0] ? FILL[7:0] : FILL[15:8];
                                    lcd.kind <= kind_data;
                                    pix_cnt  <= pix_cnt + 1'b1;
                                end
                            end
                        end
                        fill_complete: begin
                            state_q <= fill_complete;
                        end
                        default: state_q <= fill_idle;
                    endcase
                end
            end
        end
    end

    // Load rises on an idle bus and the controller answers with busy next cycle
    a_load_handshake: assert property (
        @(posedge CLK_100MHz) disable iff (rst)
        $rose(lcd.load) |-> !lcd.busy ##1 lcd.busy
    ) else $error("lcd_fill_seq: load raised while busy or not taken by controller");

endmodule

//--- src/tft_fill_top.sv
//********************
// Board top of the TFT fill demo
// LEDs show ready and streaming, debug pin shows busy
//********************
`timescale 1ns/1ns
`include "tft_consts.svh"

module tft_fill_top #(
    parameter int cols        = `TFT_COLS,
    parameter int rows        = `TFT_ROWS,
    parameter int tick_div    = `TFT_TICK_DIV,
    parameter int rst_cycles  = `TFT_RST_CYCLES,
    parameter int wake_cycles = `TFT_WAKE_CYCLES
) (
    input  logic       CLK_100MHz,
    input  logic       rst,
    input  logic [1:0] BUT,
    output logic [1:0] LED,
    output logic       TFT_CS,
    output logic       TFT_RESET,
    output logic       TFT_SDI,
    output logic       TFT_SCK,
    output logic       TFT_DC,
    output logic       TFT_DBG
);

    lcd_byte_if lcd_bus ();

    logic streaming;

    lcd_ctrl #(
        .rst_cycles  (rst_cycles),
        .wake_cycles (wake_cycles)
    ) lcd_ctrl_inst (
        .CLK_100MHz (CLK_100MHz),
        .rst        (rst),
        .host       (lcd_bus),
        .tft_reset  (TFT_RESET),
        .tft_dc     (TFT_DC),
        .sck        (TFT_SCK),
        .sdo        (TFT_SDI),
        .cs_n       (TFT_CS)
    );

    // BUT[0] restarts the fill
    lcd_fill_seq #(
        .cols     (cols),
        .rows     (rows),
        .tick_div (tick_div)
    ) lcd_fill_seq_inst (
        .CLK_100MHz (CLK_100MHz),
        .rst        (rst),
        .restart    (BUT[0]),
        .lcd        (lcd_bus),
        .streaming  (streaming)
    );

    assign LED     = {streaming, lcd_bus.ready};
    assign TFT_DBG = lcd_bus.busy;

endmodule

//--- sim/tb_clock_gen.sv
//********************
// Testbench clock, 10 ns period
// Reset held for the first cycles
//********************
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int half_period = 5,
    parameter int rst_len     = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Released on a falling edge so the DUT sees a clean level
    initial begin
        rst = 1'b1;
        repeat (rst_len) @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- sim/tb_tft_fill.sv
//********************
// Testbench for the TFT fill top level
// SPI bus decoder, byte stream check against the pattern file
// Panel reset, power-up, window, pixels, restart
//********************
`timescale 1ns/1ns

module tb_tft_fill;

    localparam int COLS         = 4;
    localparam int ROWS         = 2;
    localparam int TICK_DIV     = 3;
    localparam int RST_CYCLES   = 20;
    localparam int WAKE_CYCLES  = 40;
    localparam int N_INIT       = 4;
    localparam int N_WIN        = 11;
    localparam int N_PIX        = 2 * COLS * ROWS;
    localparam int N_PAT        = N_INIT + N_WIN + N_PIX;
    localparam int BYTE_LIMIT   = 2000;
    localparam int QUIET_CYCLES = 400;

    // Pin conditions for wait_pin
    localparam int PIN_RST_DONE  = 0;
    localparam int PIN_TFT_RESET = 1;
    localparam int PIN_READY     = 2;

    logic        clk;
    logic        rst;
    logic [1:0]  BUT;
    logic [1:0]  LED;
    logic        TFT_CS;
    logic        TFT_RESET;
    logic        TFT_SDI;
    logic        TFT_SCK;
    logic        TFT_DC;
    logic        TFT_DBG;

    // Each word is {LED nibble, DC nibble, byte}
    logic [15:0] pat [0:N_PAT-1];
    logic [15:0] rx [$];

    logic [7:0]  shift;
    logic [1:0]  frame_led;
    logic        prev_cs;
    logic        prev_sck;
    int          nbits;
    int          err_count;
    int          dbg_err;
    int          pass_count;
    int          fail_count;
    bit          timed_out;

    tb_clock_gen tb_clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    tft_fill_top #(
        .cols        (COLS),
        .rows        (ROWS),
        .tick_div    (TICK_DIV),
        .rst_cycles  (RST_CYCLES),
        .wake_cycles (WAKE_CYCLES)
    ) tft_fill_top_inst (
        .CLK_100MHz (clk),
        .rst        (rst),
        .BUT        (BUT),
        .LED        (LED),
        .TFT_CS     (TFT_CS),
        .TFT_RESET  (TFT_RESET),
        .TFT_SDI    (TFT_SDI),
        .TFT_SCK    (TFT_SCK),
        .TFT_DC     (TFT_DC),
        .TFT_DBG    (TFT_DBG)
    );

    // SPI decoder samples the pins on the falling clock edge
    always @(negedge clk) begin
        if (!TFT_CS && prev_cs) begin
            frame_led = LED;
            nbits = 0;
        end
        if (!TFT_CS && TFT_SCK && !prev_sck) begin
            shift = {shift[6:0], TFT_SDI};
            nbits = nbits + 1;
        end
        // DC is held until the next byte, so it is valid at frame end
        if (TFT_CS && !prev_cs) begin
            if (nbits != 8) begin
                $display("ERROR: SPI frame ended after %0d bits instead of 8", nbits);
                err_count++;
            end
            rx.push_back({2'b00, frame_led, 3'b000, TFT_DC, shift});
        end
        if (!TFT_CS && !TFT_DBG) begin
            if (dbg_err == 0) begin
                $display("ERROR: TFT_DBG is low while TFT_CS is low at %0t ns", $time);
            end
            dbg_err++;
            err_count++;
        end
        prev_cs = TFT_CS;
        prev_sck = TFT_SCK;
    end

    task automatic report_wrong_value(input string test, input string what,
                                      input logic [15:0] expected, input logic [15:0] actual);
        $display("MISMATCH %s %s: expected %h, actual %h", test, what, expected, actual);
        err_count++;
    endtask

    function automatic bit pin_ready(input int which);
        case (which)
            PIN_RST_DONE:  return !rst;
            PIN_TFT_RESET: return TFT_RESET;
            default:       return LED[0];
        endcase
    endfunction

    task automatic wait_pin(input int which, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (!timed_out && !pin_ready(which)) begin
            if (cycles >= limit) begin
                $display("ERROR: timeout after %0d cycles waiting for %s", limit, what);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // Queue only grows on falling edges, so it is read on rising ones
    task automatic wait_rx(input int count, input string what);
        int cycles;
        cycles = 0;
        while (!timed_out && rx.size() < count) begin
            if (cycles >= BYTE_LIMIT) begin
                $display("ERROR: timeout after %0d cycles waiting for %s", BYTE_LIMIT, what);
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    task automatic check_stream(input string test, input int pat_first,
                                input int rx_first, input int count);
        int    i;
        string what;
        for (i = 0; i < count; i++) begin
            if (rx[rx_first + i] !== pat[pat_first + i]) begin
                what = $sformatf("byte %0d (led/dc/data)", i);
                report_wrong_value(test, what, pat[pat_first + i], rx[rx_first + i]);
            end
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (!timed_out && err_count == err_before) begin
            $display("PASS %s", name);
            pass_count++;
        end else begin
            $display("FAIL %s", name);
            fail_count++;
        end
    endtask

    initial begin
        int err_before;
        int rx_base;
        BUT = 2'b00;
        prev_cs = 1'b1;
        prev_sck = 1'b0;
        shift = 8'h00;
        frame_led = 2'b00;
        nbits = 0;
        err_count = 0;
        dbg_err = 0;
        pass_count = 0;
        fail_count = 0;
        timed_out = 1'b0;
        $readmemh("sim/tft_patterns.txt", pat);

        // Panel reset
        err_before = err_count;
        @(negedge clk);
        if (TFT_RESET !== 1'b0) begin
            report_wrong_value("panel_reset", "TFT_RESET in reset", 16'h0, 16'(TFT_RESET));
        end
        if (LED !== 2'b00) begin
            report_wrong_value("panel_reset", "LED in reset", 16'h0, 16'(LED));
        end
        if (TFT_CS !== 1'b1) begin
            report_wrong_value("panel_reset", "TFT_CS in reset", 16'h1, 16'(TFT_CS));
        end
        wait_pin(PIN_RST_DONE, 20, "end of reset");
        if (!timed_out && TFT_RESET !== 1'b0) begin
            report_wrong_value("panel_reset", "TFT_RESET after reset", 16'h0, 16'(TFT_RESET));
        end
        wait_pin(PIN_TFT_RESET, 4 * RST_CYCLES, "panel reset release");
        finish_test("panel_reset", err_before);

        // Power-up commands
        err_before = err_count;
        wait_rx(N_INIT, "power-up commands");
        if (!timed_out) check_stream("power_up", 0, 0, N_INIT);
        wait_pin(PIN_READY, 20, "ready on LED[0]");
        finish_test("power_up", err_before);

        // Address window and memory write
        err_before = err_count;
        wait_rx(N_INIT + N_WIN, "address window bytes");
        if (!timed_out) check_stream("address_window", N_INIT, N_INIT, N_WIN);
        finish_test("address_window", err_before);

        // Pixel bytes followed by a quiet bus
        err_before = err_count;
        wait_rx(N_PAT, "pixel bytes");
        if (!timed_out) begin
            check_stream("pixel_stream", N_INIT + N_WIN, N_INIT + N_WIN, N_PIX);
            repeat (QUIET_CYCLES) @(posedge clk);
            if (rx.size() != N_PAT) begin
                report_wrong_value("pixel_stream", "byte count after quiet time", 16'(N_PAT),
                                   16'(rx.size()));
            end
        end
        finish_test("pixel_stream", err_before);

        // Restart through BUT[0] repeats the window and pixels
        err_before = err_count;
        rx_base = rx.size();
        @(negedge clk);
        BUT = 2'b01;
        repeat (4 * TICK_DIV) @(negedge clk);
        BUT = 2'b00;
        wait_rx(rx_base + N_WIN + N_PIX, "stream after restart");
        if (!timed_out) check_stream("restart_debug", N_INIT, rx_base, N_WIN + N_PIX);
        finish_test("restart_debug", err_before);

        $display("Tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count, err_count);
        if (!timed_out && fail_count == 0 && err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sim/tft_patterns.txt
// One word per SPI byte: LED at frame start, DC flag, byte
// LED bit 0 is ready, bit 1 is streaming; DC is 0 for commands
0011
003A
0155
0029
// Column set 0..3, page set 0..1, memory write
102A
1100
1100
1100
1103
102B
1100
1100
1100
1101
302C
// Eight pixels of 001F, high byte first
3100
311F
3100
311F
3100
311F
3100
311F
3100
311F
3100
311F
3100
311F
3100
311F

//--- verilog.f
+incdir+src
src/tft_pkg.sv
src/lcd_byte_if.sv
src/spi_byte_tx.sv
src/lcd_ctrl.sv
src/lcd_fill_seq.sv
src/tft_fill_top.sv
sim/tb_clock_gen.sv
sim/tb_tft_fill.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the TFT fill testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_tft_fill -o tb_tft_fill
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_tft_fill > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
exit 1
